/* compile.f */
+incdir+rtl
rtl/tage_pkg.sv
rtl/tage_hash.sv
rtl/tage_base.sv
rtl/tage_bank.sv
rtl/tage_update.sv
rtl/tage_regs.sv
rtl/tage_top.sv
sim/tb_clock.sv
sim/tage_tb.sv

/* rtl/tage_bank.sv */
`timescale 1ns/1ps
`include "tage_defines.svh"

module tage_bank (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rd_en,
	input  logic [`TAGE_IDX_W-1:0] rd_idx,
	input  logic [`TAGE_TAG_W-1:0] rd_tag,
	output logic                   hit,
	output logic [`TAGE_CTR_W-1:0] ctr,
	output logic [`TAGE_U_W-1:0]   u,
	input  tage_pkg::tage_wr_t     wr,
	input  logic                   uclr_en,
	input  logic [`TAGE_IDX_W-1:0] uclr_idx
);

	logic                   valid_mem [`TAGE_DEPTH];
	logic [`TAGE_TAG_W-1:0] tag_mem [`TAGE_DEPTH];
	logic [`TAGE_CTR_W-1:0] ctr_mem [`TAGE_DEPTH];
	logic [`TAGE_U_W-1:0]   u_mem [`TAGE_DEPTH];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < `TAGE_DEPTH; i++) begin
				valid_mem[i] <= 1'b0;
				tag_mem[i] <= '0;
				ctr_mem[i] <= '0;
				u_mem[i] <= '0;
			end
		end else begin
			if (wr.en && wr.we_entry) begin
				valid_mem[wr.idx] <= 1'b1;
				tag_mem[wr.idx] <= wr.tag;
				ctr_mem[wr.idx] <= wr.ctr;
				u_mem[wr.idx] <= wr.u;
			end else if (wr.en && wr.we_u) begin
				u_mem[wr.idx] <= wr.u;
			end
			// sweep wins over a write to the same entry
			if (uclr_en) begin
				u_mem[uclr_idx] <= '0;
			end
		end
	end

	// tag compare is taken at read time, hit is ready with the data
	always_ff @(posedge clk) begin
		if (rd_en) begin
			hit <= valid_mem[rd_idx] && (tag_mem[rd_idx] == rd_tag);
			ctr <= ctr_mem[rd_idx];
			u <= u_mem[rd_idx];
		end
	end

endmodule

/* rtl/tage_base.sv */
`timescale 1ns/1ps
`include "tage_defines.svh"

module tage_base (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    rd_en,
	input  logic [`TAGE_IDX_W-1:0]  rd_idx,
	output logic [`TAGE_BASE_W-1:0] rd_ctr,
	input  logic                    wr_en,
	input  logic [`TAGE_IDX_W-1:0]  wr_idx,
	input  logic [`TAGE_BASE_W-1:0] wr_ctr
);

	logic [`TAGE_BASE_W-1:0] mem [`TAGE_DEPTH];

	// zero is strongly not taken
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < `TAGE_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[wr_idx] <= wr_ctr;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_ctr <= mem[rd_idx];
		end
	end

endmodule

/* rtl/tage_defines.svh */
`ifndef TAGE_DEFINES_SVH
`define TAGE_DEFINES_SVH

`define TAGE_PC_W      32
// instruction offset bits skipped by every pc slice
`define TAGE_PC_LSB    2
`define TAGE_HIST_W    16
`define TAGE_BANKS     2
`define TAGE_IDX_W     6
`define TAGE_DEPTH     (1 << `TAGE_IDX_W)
`define TAGE_TAG_W     8
`define TAGE_CTR_W     3
`define TAGE_BASE_W    2
`define TAGE_U_W       2
`define TAGE_UCLR_W    16
`define TAGE_UCLR_RST  1024
`define TAGE_REG_W     32

`endif

/* rtl/tage_hash.sv */
`timescale 1ns/1ps
`include "tage_defines.svh"

module tage_hash #(
	parameter int HIST_LEN = `TAGE_HIST_W
) (
	input  logic [`TAGE_PC_W-1:0]   pc,
	input  logic [`TAGE_HIST_W-1:0] hist,
	output logic [`TAGE_IDX_W-1:0]  idx,
	output logic [`TAGE_TAG_W-1:0]  tag
);

	// bit 0 of hist is the most recent outcome
	localparam logic [`TAGE_HIST_W-1:0] HIST_MASK =
		{`TAGE_HIST_W{1'b1}} >> (`TAGE_HIST_W - HIST_LEN);

	logic [`TAGE_HIST_W-1:0] h;
	logic [`TAGE_IDX_W-1:0] fold_idx;
	logic [`TAGE_TAG_W-1:0] fold_tag;

	always_comb begin
		h = hist & HIST_MASK;
		fold_idx = '0;
		fold_tag = '0;
		for (int i = 0; i < `TAGE_HIST_W; i++) begin
			fold_idx[i % `TAGE_IDX_W] ^= h[i];
			fold_tag[(i + 1) % `TAGE_TAG_W] ^= h[i];
		end
	end

	assign idx = pc[`TAGE_PC_LSB +: `TAGE_IDX_W]
		^ pc[`TAGE_PC_LSB + `TAGE_IDX_W +: `TAGE_IDX_W] ^ fold_idx;
	assign tag = pc[`TAGE_PC_LSB + `TAGE_IDX_W +: `TAGE_TAG_W]
		^ pc[`TAGE_PC_LSB + 2 * `TAGE_IDX_W +: `TAGE_TAG_W] ^ fold_tag;

endmodule

/* rtl/tage_pkg.sv */
`include "tage_defines.svh"

package tage_pkg;

	typedef enum logic [1:0] {
		REG_CTRL = 2'd0,
		REG_UCLR = 2'd1,
		REG_MISS = 2'd2
	} reg_addr_e;

	typedef enum logic {
		UCLR_IDLE,
		UCLR_SWEEP
	} uclr_state_e;

	typedef struct packed {
		logic [`TAGE_BANKS-1:0] hit;
		logic [`TAGE_BANKS-1:0] provider;
		logic [`TAGE_CTR_W-1:0] provider_ctr;
		logic [`TAGE_BASE_W-1:0] base_ctr;
		logic alt_pred;
		logic pred;
		logic [`TAGE_BANKS-1:0][`TAGE_U_W-1:0] u;
	} tage_meta_t;

	typedef struct packed {
		logic [`TAGE_PC_W-1:0] pc;
		logic [`TAGE_HIST_W-1:0] history;
	} tage_req_t;

	typedef struct packed {
		logic pred;
		tage_meta_t meta;
	} tage_resp_t;

	typedef struct packed {
		logic [`TAGE_PC_W-1:0] pc;
		logic [`TAGE_HIST_W-1:0] history;
		logic taken;
		tage_meta_t meta;
	} tage_upd_t;

	typedef struct packed {
		logic tagged_en;
		logic [`TAGE_UCLR_W-1:0] uclr_period;
	} tage_cfg_t;

	typedef struct packed {
		logic en;
		logic [`TAGE_IDX_W-1:0] idx;
		logic [`TAGE_TAG_W-1:0] tag;
		logic [`TAGE_CTR_W-1:0] ctr;
		logic [`TAGE_U_W-1:0] u;
		logic we_entry;
		logic we_u;
	} tage_wr_t;

endpackage

/* rtl/tage_regs.sv */
`timescale 1ns/1ps
`include "tage_defines.svh"

module tage_regs (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cfg_we,
	input  tage_pkg::reg_addr_e    cfg_addr,
	input  logic [`TAGE_REG_W-1:0] cfg_wdata,
	output logic [`TAGE_REG_W-1:0] cfg_rdata,
	input  logic                   miss,
	output tage_pkg::tage_cfg_t    cfg
);

	import tage_pkg::*;

	logic [`TAGE_REG_W-1:0] miss_cnt;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cfg.tagged_en <= 1'b1;
			cfg.uclr_period <= `TAGE_UCLR_W'(`TAGE_UCLR_RST);
			miss_cnt <= '0;
		end else begin
			if (miss && !(&miss_cnt)) begin
				miss_cnt <= miss_cnt + 1'b1;
			end
			// any write to the miss register clears it
			if (cfg_we) begin
				case (cfg_addr)
					REG_CTRL: cfg.tagged_en <= cfg_wdata[0];
					REG_UCLR: cfg.uclr_period <= cfg_wdata[`TAGE_UCLR_W-1:0];
					REG_MISS: miss_cnt <= '0;
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		case (cfg_addr)
			REG_CTRL: cfg_rdata = {{(`TAGE_REG_W - 1){1'b0}}, cfg.tagged_en};
			REG_UCLR: cfg_rdata = {{(`TAGE_REG_W - `TAGE_UCLR_W){1'b0}}, cfg.uclr_period};
			REG_MISS: cfg_rdata = miss_cnt;
			default: cfg_rdata = '0;
		endcase
	end

endmodule

/* rtl/tage_top.sv */
`timescale 1ns/1ps
`include "tage_defines.svh"

module tage_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_valid,
	output logic                   req_ready,
	input  tage_pkg::tage_req_t    req,
	output logic                   resp_valid,
	input  logic                   resp_ready,
	output tage_pkg::tage_resp_t   resp,
	input  logic                   upd_valid,
	output logic                   upd_ready,
	input  tage_pkg::tage_upd_t    upd,
	input  logic                   cfg_we,
	input  tage_pkg::reg_addr_e    cfg_addr,
	input  logic [`TAGE_REG_W-1:0] cfg_wdata,
	output logic [`TAGE_REG_W-1:0] cfg_rdata
);

	import tage_pkg::*;

	logic req_fire;
	logic [`TAGE_BANKS-1:0][`TAGE_IDX_W-1:0] rd_idx;
	logic [`TAGE_BANKS-1:0][`TAGE_TAG_W-1:0] rd_tag;
	logic [`TAGE_BANKS-1:0] hit;
	logic [`TAGE_BANKS-1:0][`TAGE_CTR_W-1:0] bank_ctr;
	logic [`TAGE_BANKS-1:0][`TAGE_U_W-1:0] bank_u;
	logic [`TAGE_BASE_W-1:0] base_ctr;
	tage_wr_t [`TAGE_BANKS-1:0] bank_wr;
	logic base_wr_en;
	logic [`TAGE_IDX_W-1:0] base_wr_idx;
	logic [`TAGE_BASE_W-1:0] base_wr_ctr;
	logic uclr_en;
	logic [`TAGE_IDX_W-1:0] uclr_idx;
	logic miss;
	tage_cfg_t cfg;
	tage_meta_t meta;

	assign req_ready = !resp_valid || resp_ready;
	assign req_fire = req_valid && req_ready;

	for (genvar b = 0; b < `TAGE_BANKS; b++) begin : gen_bank
		tage_hash #(
			.HIST_LEN(`TAGE_HIST_W >> (`TAGE_BANKS - 1 - b))
		) hash_inst (
			.pc(req.pc),
			.hist(req.history),
			.idx(rd_idx[b]),
			.tag(rd_tag[b])
		);

		tage_bank bank_inst (
			.clk(clk),
			.rst(rst),
			.rd_en(req_fire),
			.rd_idx(rd_idx[b]),
			.rd_tag(rd_tag[b]),
			.hit(hit[b]),
			.ctr(bank_ctr[b]),
			.u(bank_u[b]),
			.wr(bank_wr[b]),
			.uclr_en(uclr_en),
			.uclr_idx(uclr_idx)
		);
	end

	tage_base base_inst (
		.clk(clk),
		.rst(rst),
		.rd_en(req_fire),
		.rd_idx(req.pc[`TAGE_PC_LSB +: `TAGE_IDX_W]),
		.rd_ctr(base_ctr),
		.wr_en(base_wr_en),
		.wr_idx(base_wr_idx),
		.wr_ctr(base_wr_ctr)
	);

	tage_update update_inst (
		.clk(clk),
		.rst(rst),
		.upd_valid(upd_valid),
		.upd_ready(upd_ready),
		.upd(upd),
		.cfg(cfg),
		.bank_wr(bank_wr),
		.base_wr_en(base_wr_en),
		.base_wr_idx(base_wr_idx),
		.base_wr_ctr(base_wr_ctr),
		.uclr_en(uclr_en),
		.uclr_idx(uclr_idx),
		.miss(miss)
	);

	tage_regs regs_inst (
		.clk(clk),
		.rst(rst),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.miss(miss),
		.cfg(cfg)
	);

	// table outputs only move on acceptance, so resp holds under back-pressure
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			resp_valid <= 1'b0;
		end else if (req_fire) begin
			resp_valid <= 1'b1;
		end else if (resp_ready) begin
			resp_valid <= 1'b0;
		end
	end

	// longest hitting history provides
	always_comb begin
		meta = '0;
		meta.hit = hit;
		meta.base_ctr = base_ctr;
		meta.alt_pred = base_ctr[`TAGE_BASE_W-1];
		meta.u = bank_u;
		for (int b = 0; b < `TAGE_BANKS; b++) begin
			if (hit[b]) begin
				meta.provider = '0;
				meta.provider[b] = 1'b1;
				meta.provider_ctr = bank_ctr[b];
			end
		end
		meta.pred = (|hit) ? meta.provider_ctr[`TAGE_CTR_W-1] : meta.alt_pred;
	end

	assign resp.pred = meta.pred;
	assign resp.meta = meta;

endmodule

/* rtl/tage_update.sv */
`timescale 1ns/1ps
`include "tage_defines.svh"

module tage_update (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 upd_valid,
	output logic                                 upd_ready,
	input  tage_pkg::tage_upd_t                  upd,
	input  tage_pkg::tage_cfg_t                  cfg,
	output tage_pkg::tage_wr_t [`TAGE_BANKS-1:0] bank_wr,
	output logic                                 base_wr_en,
	output logic [`TAGE_IDX_W-1:0]               base_wr_idx,
	output logic [`TAGE_BASE_W-1:0]              base_wr_ctr,
	output logic                                 uclr_en,
	output logic [`TAGE_IDX_W-1:0]               uclr_idx,
	output logic                                 miss
);

	import tage_pkg::*;

	logic fire;
	logic mispred;
	logic has_prov;
	logic prov_dir;
	logic use_chg;
	logic alloc_en;
	logic seen;
	logic [`TAGE_BANKS-1:0] cand;
	logic [`TAGE_BANKS-1:0] free;
	logic [`TAGE_BANKS-1:0] alloc;
	logic [`TAGE_BANKS-1:0] dec_u;
	logic [`TAGE_BANKS-1:0][`TAGE_U_W-1:0] u_dec;
	logic [`TAGE_BANKS-1:0][`TAGE_IDX_W-1:0] upd_idx;
	logic [`TAGE_BANKS-1:0][`TAGE_TAG_W-1:0] upd_tag;
	logic [`TAGE_CTR_W-1:0] prov_ctr_new;
	logic [`TAGE_CTR_W-1:0] weak_ctr;
	logic [`TAGE_U_W-1:0] prov_u_old;
	logic [`TAGE_U_W-1:0] prov_u_new;
	uclr_state_e state;
	logic [`TAGE_IDX_W-1:0] sweep_idx;
	logic [`TAGE_UCLR_W-1:0] upd_cnt;
	logic [`TAGE_UCLR_W-1:0] cnt_next;

	for (genvar b = 0; b < `TAGE_BANKS; b++) begin : gen_hash
		tage_hash #(
			.HIST_LEN(`TAGE_HIST_W >> (`TAGE_BANKS - 1 - b))
		) hash_inst (
			.pc(upd.pc),
			.hist(upd.history),
			.idx(upd_idx[b]),
			.tag(upd_tag[b])
		);
	end

	assign fire = upd_valid && upd_ready;
	assign mispred = upd.meta.pred != upd.taken;
	assign has_prov = |upd.meta.provider;
	assign prov_dir = upd.meta.provider_ctr[`TAGE_CTR_W-1];
	assign use_chg = has_prov && (prov_dir != upd.meta.alt_pred);
	assign alloc_en = mispred && cfg.tagged_en;
	assign weak_ctr = {upd.taken, {(`TAGE_CTR_W - 1){!upd.taken}}};
	assign miss = fire && mispred;

	// saturating counters toward the outcome
	always_comb begin
		prov_ctr_new = upd.meta.provider_ctr;
		if (upd.taken && !(&upd.meta.provider_ctr)) begin
			prov_ctr_new = upd.meta.provider_ctr + 1'b1;
		end else if (!upd.taken && (|upd.meta.provider_ctr)) begin
			prov_ctr_new = upd.meta.provider_ctr - 1'b1;
		end
		base_wr_ctr = upd.meta.base_ctr;
		if (upd.taken && !(&upd.meta.base_ctr)) begin
			base_wr_ctr = upd.meta.base_ctr + 1'b1;
		end else if (!upd.taken && (|upd.meta.base_ctr)) begin
			base_wr_ctr = upd.meta.base_ctr - 1'b1;
		end
	end

	always_comb begin
		prov_u_old = '0;
		for (int b = 0; b < `TAGE_BANKS; b++) begin
			if (upd.meta.provider[b]) begin
				prov_u_old = upd.meta.u[b];
			end
		end
		prov_u_new = prov_u_old;
		if (use_chg && (prov_dir == upd.taken) && !(&prov_u_old)) begin
			prov_u_new = prov_u_old + 1'b1;
		end else if (use_chg && (prov_dir != upd.taken) && (|prov_u_old)) begin
			prov_u_new = prov_u_old - 1'b1;
		end
	end

	// candidates sit above the provider, or are all banks without one
	always_comb begin
		seen = 1'b0;
		for (int b = 0; b < `TAGE_BANKS; b++) begin
			cand[b] = alloc_en && (!has_prov || seen);
			free[b] = cand[b] && (upd.meta.u[b] == '0);
			u_dec[b] = (upd.meta.u[b] == '0) ? '0 : upd.meta.u[b] - 1'b1;
			seen = seen | upd.meta.provider[b];
		end
		alloc = '0;
		for (int b = `TAGE_BANKS - 1; b >= 0; b--) begin
			if (free[b]) begin
				alloc = '0;
				alloc[b] = 1'b1;
			end
		end
		dec_u = (|free) ? '0 : cand;
	end

	always_comb begin
		for (int b = 0; b < `TAGE_BANKS; b++) begin
			bank_wr[b].en = fire && (upd.meta.provider[b] || alloc[b] || dec_u[b]);
			bank_wr[b].idx = upd_idx[b];
			bank_wr[b].tag = upd_tag[b];
			bank_wr[b].we_entry = upd.meta.provider[b] || alloc[b];
			bank_wr[b].we_u = dec_u[b];
			if (alloc[b]) begin
				bank_wr[b].ctr = weak_ctr;
				bank_wr[b].u = '0;
			end else begin
				bank_wr[b].ctr = prov_ctr_new;
				bank_wr[b].u = upd.meta.provider[b] ? prov_u_new : u_dec[b];
			end
		end
	end

	assign base_wr_en = fire && !has_prov;
	assign base_wr_idx = upd.pc[`TAGE_PC_LSB +: `TAGE_IDX_W];

	assign cnt_next = upd_cnt + 1'b1;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= UCLR_IDLE;
			sweep_idx <= '0;
			upd_cnt <= '0;
		end else begin
			case (state)
				UCLR_IDLE: begin
					if (fire && (cnt_next >= cfg.uclr_period)) begin
						upd_cnt <= '0;
						sweep_idx <= '0;
						state <= UCLR_SWEEP;
					end else if (fire) begin
						upd_cnt <= cnt_next;
					end
				end
				UCLR_SWEEP: begin
					sweep_idx <= sweep_idx + 1'b1;
					if (&sweep_idx) begin
						state <= UCLR_IDLE;
					end
				end
				default: state <= UCLR_IDLE;
			endcase
		end
	end

	assign upd_ready = state == UCLR_IDLE;
	assign uclr_en = state == UCLR_SWEEP;
	assign uclr_idx = sweep_idx;

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the TAGE testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module tage_tb -o tage_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tage_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "simulation did not report a pass"
exit 1

/* sim/tage_tb.sv */
`timescale 1ns/1ps
`include "tage_defines.svh"

module tage_tb;

	import tage_pkg::*;

	// longest run needs a few hundred cycles
	localparam int MAX_CYCLES = 3000;
	localparam logic [`TAGE_PC_W-1:0] PC2 = 32'h0000_0040;
	localparam logic [`TAGE_PC_W-1:0] PC3 = 32'h0000_0080;
	localparam logic [`TAGE_HIST_W-1:0] HIST = 16'h5a3c;

	logic clk;
	logic rst;
	logic req_valid;
	logic req_ready;
	tage_req_t req;
	logic resp_valid;
	logic resp_ready;
	tage_resp_t resp;
	logic upd_valid;
	logic upd_ready;
	tage_upd_t upd;
	logic cfg_we;
	reg_addr_e cfg_addr;
	logic [`TAGE_REG_W-1:0] cfg_wdata;
	logic [`TAGE_REG_W-1:0] cfg_rdata;

	int errors = 0;
	int n_pass = 0;
	int n_fail = 0;
	int cycles = 0;
	int exp_miss = 0;
	logic [`TAGE_BASE_W-1:0] exp_base3;
	logic prev_fire;
	logic prev_hold;
	tage_resp_t prev_resp;

	tb_clock #(.PERIOD(8)) clock_inst (.clk(clk));

	tage_top tage_top_inst (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req(req),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp(resp),
		.upd_valid(upd_valid),
		.upd_ready(upd_ready),
		.upd(upd),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata)
	);

	task automatic check(input bit cond, input string msg);
		assert (cond) else begin
			errors++;
			$display("CHECK FAILED at time %0t: %s", $time, msg);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			n_pass++;
			$display("test %s: passed", name);
		end else begin
			n_fail++;
			$display("test %s: failed with %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic write_reg(input reg_addr_e addr, input logic [`TAGE_REG_W-1:0] data);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_addr <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	task automatic read_reg(input reg_addr_e addr, output logic [`TAGE_REG_W-1:0] data);
		@(posedge clk);
		cfg_addr <= addr;
		@(negedge clk);
		data = cfg_rdata;
	endtask

	// response transfers on the edge after return
	task automatic lookup(input logic [`TAGE_PC_W-1:0] pc, input logic [`TAGE_HIST_W-1:0] hist,
		output tage_resp_t r);
		tage_req_t q;
		q.pc = pc;
		q.history = hist;
		@(posedge clk);
		req_valid <= 1'b1;
		req <= q;
		resp_ready <= 1'b1;
		do @(negedge clk); while (!req_ready);
		@(posedge clk);
		req_valid <= 1'b0;
		do @(negedge clk); while (!resp_valid);
		r = resp;
	endtask

	// response stalls for a few cycles while a second request waits
	task automatic held_lookup(input logic [`TAGE_PC_W-1:0] pc,
		input logic [`TAGE_PC_W-1:0] wait_pc, input int hold, output tage_resp_t r);
		tage_req_t q;
		tage_req_t q_wait;
		q.pc = pc;
		q.history = HIST;
		q_wait.pc = wait_pc;
		q_wait.history = HIST;
		@(posedge clk);
		req_valid <= 1'b1;
		req <= q;
		resp_ready <= 1'b0;
		do @(negedge clk); while (!req_ready);
		@(posedge clk);
		req <= q_wait;
		repeat (hold) @(negedge clk);
		r = resp;
		@(posedge clk);
		req_valid <= 1'b0;
		resp_ready <= 1'b1;
	endtask

	task automatic send_update(input logic [`TAGE_PC_W-1:0] pc,
		input logic [`TAGE_HIST_W-1:0] hist, input logic taken, input tage_meta_t m);
		tage_upd_t u;
		u.pc = pc;
		u.history = hist;
		u.taken = taken;
		u.meta = m;
		if (m.pred != taken) begin
			exp_miss++;
		end
		@(posedge clk);
		upd_valid <= 1'b1;
		upd <= u;
		do @(negedge clk); while (!upd_ready);
		@(posedge clk);
		upd_valid <= 1'b0;
	endtask

	// resp_valid follows acceptance by one cycle and resp holds under back-pressure
	always @(negedge clk) begin
		if (!rst) begin
			prev_fire = 1'b0;
			prev_hold = 1'b0;
		end else begin
			if (prev_fire) begin
				check(resp_valid, "resp_valid low one cycle after acceptance");
			end else if (prev_hold) begin
				check(resp_valid, "resp_valid dropped while resp_ready low");
				check(resp == prev_resp, "resp changed while resp_ready low");
			end else begin
				check(!resp_valid, "resp_valid high without an acceptance");
			end
			if (resp_valid && !resp_ready) begin
				check(!req_ready, "request port ready while a response is held");
			end else begin
				check(req_ready, "request port not ready with the response register free");
			end
			prev_fire = req_valid && req_ready;
			prev_hold = resp_valid && !resp_ready;
			prev_resp = resp;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic test_reset_lookups();
		int e0;
		logic [31:0] rnd;
		logic [`TAGE_REG_W-1:0] d;
		tage_req_t q;
		bit done;
		e0 = errors;
		read_reg(REG_CTRL, d);
		check(d == 32'd1, "tagged_en not set after reset");
		read_reg(REG_UCLR, d);
		check(d == 32'd1024, "clear period not 1024 after reset");
		read_reg(REG_MISS, d);
		check(d == 32'd0, "miss count not zero after reset");
		for (int i = 0; i < 16; i++) begin
			rnd = $urandom;
			q.pc = $urandom;
			q.history = rnd[15:0];
			@(posedge clk);
			req_valid <= 1'b1;
			req <= q;
			resp_ready <= rnd[16];
			do @(negedge clk); while (!req_ready);
			@(posedge clk);
			req_valid <= 1'b0;
			done = 1'b0;
			while (!done) begin
				@(negedge clk);
				check(!resp.pred, "empty tables predict taken");
				check(resp.meta.hit == '0 && resp.meta.provider == '0,
					"hit on empty tables");
				if (resp_ready) begin
					done = 1'b1;
				end else begin
					@(posedge clk);
					rnd = $urandom;
					resp_ready <= rnd[0];
				end
			end
		end
		finish_test("reset lookups", e0);
	endtask

	task automatic test_base_only();
		int e0;
		tage_resp_t r;
		logic [`TAGE_REG_W-1:0] d;
		logic [`TAGE_BASE_W-1:0] exp_base;
		e0 = errors;
		write_reg(REG_CTRL, 32'd0);
		read_reg(REG_CTRL, d);
		check(d == 32'd0, "tagged_en did not clear");
		exp_base = '0;
		for (int i = 0; i < 5; i++) begin
			lookup(PC2, HIST, r);
			check(r.meta.base_ctr == exp_base, "base counter off");
			check(r.pred == exp_base[`TAGE_BASE_W-1] && r.meta.pred == exp_base[`TAGE_BASE_W-1],
				"base prediction off");
			check(r.meta.alt_pred == exp_base[`TAGE_BASE_W-1],
				"alt prediction not the base direction");
			check(r.meta.hit == '0, "tagged bank hit with tagged_en clear");
			send_update(PC2, HIST, 1'b1, r.meta);
			if (exp_base != '1) begin
				exp_base = exp_base + 2'd1;
			end
		end
		lookup(PC2, HIST, r);
		check(r.pred, "base did not turn taken");
		check(r.meta.hit == '0, "tagged bank hit with tagged_en clear");
		finish_test("base only", e0);
	endtask

	task automatic test_alloc_bank0();
		int e0;
		tage_resp_t r;
		e0 = errors;
		write_reg(REG_CTRL, 32'd1);
		exp_base3 = '0;
		lookup(PC3, HIST, r);
		check(r.meta.hit == '0 && !r.pred, "fresh pc not a base miss");
		send_update(PC3, HIST, 1'b1, r.meta);
		exp_base3 = exp_base3 + 2'd1;
		lookup(PC3, HIST, r);
		check(r.meta.hit == 2'b01, "bank 0 not hit after allocation");
		check(r.meta.provider == 2'b01, "bank 0 not provider");
		check(r.meta.provider_ctr == 3'd4, "new entry not weak taken");
		check(r.pred, "allocated entry does not predict taken");
		finish_test("alloc bank 0", e0);
	endtask

	task automatic test_alloc_bank1();
		int e0;
		tage_resp_t r;
		e0 = errors;
		lookup(PC3, HIST, r);
		send_update(PC3, HIST, 1'b0, r.meta);
		lookup(PC3, HIST, r);
		check(r.meta.hit[1], "bank 1 not hit after allocation");
		check(r.meta.provider == 2'b10, "bank 1 not provider");
		check(r.meta.provider_ctr == 3'd3, "new entry not weak not taken");
		check(r.pred == 1'b0, "prediction does not follow bank 1");
		// PC2 waits behind the held bank 1 response
		held_lookup(PC3, PC2, 3, r);
		check(r.meta.provider == 2'b10 && !r.pred, "held response is not the PC3 lookup");
		finish_test("alloc bank 1", e0);
	endtask

	task automatic test_miss_and_clear();
		int e0;
		tage_resp_t r;
		logic [`TAGE_REG_W-1:0] d;
		logic [`TAGE_CTR_W-1:0] exp_ctr;
		logic [`TAGE_U_W-1:0] exp_u;
		logic alt;
		e0 = errors;
		write_reg(REG_UCLR, 32'd4);
		read_reg(REG_UCLR, d);
		check(d == 32'd4, "clear period did not update");
		// update count is already past the new period so this mispredict starts a sweep
		lookup(PC2, HIST, r);
		check(r.meta.hit == '0 && r.pred, "PC2 not a taken base prediction");
		send_update(PC2, HIST, 1'b0, r.meta);
		do @(negedge clk); while (!upd_ready);
		// bank 0 disagrees with the taken base and is right
		lookup(PC2, HIST, r);
		check(r.meta.provider == 2'b01 && !r.pred, "bank 0 not provider for PC2");
		send_update(PC2, HIST, 1'b0, r.meta);
		lookup(PC2, HIST, r);
		check(r.meta.u[0] == 2'd1, "bank 0 useful counter did not rise");
		exp_ctr = 3'd3;
		exp_u = '0;
		alt = exp_base3[`TAGE_BASE_W-1];
		for (int k = 0; k < 3; k++) begin
			lookup(PC3, HIST, r);
			check(r.meta.provider == 2'b10, "bank 1 not provider");
			check(r.meta.provider_ctr == exp_ctr, "bank 1 counter off");
			check(r.meta.u[1] == exp_u, "bank 1 useful counter off");
			send_update(PC3, HIST, 1'b1, r.meta);
			if (exp_ctr[`TAGE_CTR_W-1] != alt && exp_ctr[`TAGE_CTR_W-1] && exp_u != '1) begin
				exp_u = exp_u + 2'd1;
			end
			if (exp_ctr != '1) begin
				exp_ctr = exp_ctr + 3'd1;
			end
			@(negedge clk);
			check(upd_ready == (k != 2), "upd_ready wrong around the clear period");
		end
		do @(negedge clk); while (!upd_ready);
		lookup(PC3, HIST, r);
		check(r.meta.hit[1], "bank 1 entry lost in sweep");
		check(r.meta.u[1] == '0, "bank 1 useful counter not cleared");
		lookup(PC2, HIST, r);
		check(r.meta.hit[0], "bank 0 entry lost in sweep");
		check(r.meta.u[0] == '0, "bank 0 useful counter not cleared");
		read_reg(REG_MISS, d);
		check(d == 32'(exp_miss), "miss count does not match mispredicts sent");
		write_reg(REG_MISS, 32'd0);
		read_reg(REG_MISS, d);
		check(d == 32'd0, "miss count did not clear");
		finish_test("miss count and clear", e0);
	endtask

	initial begin
		void'($urandom(32'h696b4eaf));
		rst = 1'b0;
		req_valid = 1'b0;
		req = '0;
		resp_ready = 1'b0;
		upd_valid = 1'b0;
		upd = '0;
		cfg_we = 1'b0;
		cfg_addr = REG_CTRL;
		cfg_wdata = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b1;

		test_reset_lookups();
		test_base_only();
		test_alloc_bank0();
		test_alloc_bank1();
		test_miss_and_clear();

		$display("tests passed %0d, tests failed %0d, check errors %0d", n_pass, n_fail, errors);
		if (n_fail == 0 && errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule
